// File: build.f
source/uarch_pkg.sv
source/reg_file.sv
source/dispatch_stage.sv
source/alu_stage.sv
source/writeback_stage.sv
source/exec_top.sv
dv/exec_asserts.sv
dv/exec_tb.sv

// File: Bender.yml
package:
  name: exec_subsys

sources:
  # design, package first
  - files:
      - source/uarch_pkg.sv
      - source/reg_file.sv
      - source/dispatch_stage.sv
      - source/alu_stage.sv
      - source/writeback_stage.sv
      - source/exec_top.sv

  # verification
  - target: test
    files:
      - dv/exec_asserts.sv
      - dv/exec_tb.sv

// File: dv/exec_tb.sv
// testbench for exec_top
// lfsr stimulus, issue-order reference model, commit checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
  import uarch_pkg::*;

  localparam int unsigned seq_num_bits = 5;
  localparam int num_random    = 400;
  localparam int num_ops       = 531 + num_random;  // setup, burst, edge, chain, x0, random
  localparam int watchdog_cyc  = num_ops * 40 + 200;

  typedef struct packed {
    commit_t     c;
    logic        timed;      // check fixed 3-cycle latency
    logic [31:0] issue_cyc;
  } exp_t;

  logic    clk = 1'b0;
  logic    rst;
  logic    issue_val;
  logic    issue_rdy;
  issue_t  issue;
  logic    commit_val;
  logic    commit_rdy;
  commit_t commit;

  logic [31:0] lfsr = 32'h0e26_600d;
  logic [31:0] cyc = '0;
  data_t       model_regs [32];  // architectural state in issue order
  exp_t        exp_q [$];
  int          seq_cnt = 0;
  addr_t       next_pc = 32'h0000_1000;
  logic        bp_on = 1'b0;     // random commit_rdy when set
  int          issued = 0;
  int          commits = 0;
  int          value_errs = 0;
  int          other_errs = 0;

  exec_top #(.seq_num_bits(seq_num_bits)) dut (
    .clk, .rst,
    .issue_val, .issue_rdy, .issue,
    .commit_val, .commit_rdy, .commit
  );

  always #10 clk = ~clk;  // 20 ns period

  always @(posedge clk) cyc <= cyc + 1;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // zero, all-ones, min negative, max shift, max positive
  function automatic data_t edge_val(input int k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      3:       return 32'd31;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  // rv32i semantics, written out bit by bit where signedness matters
  function automatic data_t ref_alu(input rv_uop uop, input data_t a, input data_t b);
    data_t      r;
    logic [4:0] sh;
    sh = b[4:0];
    r  = '0;
    case (uop)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a + ~b + 32'd1;  // two's complement
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SLL:  r = a << sh;
      OP_SRL:  r = a >> sh;
      OP_SRA: begin
        r = a >> sh;
        if (a[31]) r = r | ~(32'hffff_ffff >> sh);  // refill top bits
      end
      OP_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      OP_SLTU: r = {31'b0, a < b};
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic next_cycle();
    logic [31:0] rnd;
    @(posedge clk);
    #2;
    rnd = lfsr_bits(1);
    commit_rdy = bp_on ? rnd[0] : 1'b1;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want, input addr_t pc);
    value_errs++;
    $display("FAIL @%0t: %s is %h, expected %h (pc %h)", $time, what, got, want, pc);
  endtask

  // holds one op on the issue link until it is taken, then updates the model
  task automatic issue_op(input rv_uop uop, input int rs1, input int rs2, input data_t imm,
                          input logic use_imm, input int rd, input logic timed);
    issue_t op;
    exp_t   e;
    data_t  b;
    logic   took;
    int     tries;
    op.pc      = next_pc;
    op.uop     = uop;
    op.rs1     = reg_idx_t'(rs1);
    op.rs2     = reg_idx_t'(rs2);
    op.imm     = imm;
    op.use_imm = use_imm;
    op.waddr   = reg_idx_t'(rd);
    issue      = op;
    issue_val  = 1'b1;
    took       = 1'b0;
    tries      = 0;
    while (!took) begin
      @(negedge clk);
      took = issue_rdy;
      tries++;
      if (took) begin
        b             = use_imm ? imm : model_regs[rs2];
        e.c.pc        = op.pc;
        e.c.seq_num   = seq_t'(seq_cnt);
        e.c.waddr     = op.waddr;
        e.c.wdata     = ref_alu(uop, model_regs[rs1], b);
        e.timed       = timed;
        e.issue_cyc   = cyc;
        exp_q.push_back(e);
        if (rd != 0) model_regs[rd] = e.c.wdata;  // x0 stays zero
        seq_cnt = (seq_cnt + 1) % (1 << seq_num_bits);
        next_pc = next_pc + 32'd4;
        issued++;
      end
      next_cycle();
    end
    issue_val = 1'b0;
    assert (!timed || tries == 1) else begin
      other_errs++;
      $display("independent op at pc %h waited %0d cycles at issue", op.pc, tries - 1);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) next_cycle();
    next_cycle();
  endtask

  // --------------------------------------------------
  // commit checker, sampled mid-cycle
  // --------------------------------------------------

  always @(negedge clk) begin
    exp_t e;
    if (!rst && commit_val && commit_rdy) begin
      commits++;
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("commit at pc %h with no matching issued op", commit.pc);
      end else begin
        e = exp_q.pop_front();
        assert (commit.pc == e.c.pc) else report_mismatch("pc", commit.pc, e.c.pc, e.c.pc);
        assert (commit.seq_num == e.c.seq_num)
          else report_mismatch("seq_num", 32'(commit.seq_num), 32'(e.c.seq_num), e.c.pc);
        assert (commit.waddr == e.c.waddr)
          else report_mismatch("waddr", 32'(commit.waddr), 32'(e.c.waddr), e.c.pc);
        assert (commit.wdata == e.c.wdata)
          else report_mismatch("wdata", commit.wdata, e.c.wdata, e.c.pc);
        assert (!e.timed || (cyc - e.issue_cyc) == 32'd3)
          else report_mismatch("latency", cyc - e.issue_cyc, 32'd3, e.c.pc);
      end
    end
  end

  initial begin
    repeat (watchdog_cyc) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cyc);
    $display("Something failed");
    $finish;
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    logic [31:0] rnd;
    rv_uop       r_uop;
    logic [2:0]  r_sel;
    data_t       r_imm;
    int          k;
    rst        = 1'b1;
    issue_val  = 1'b0;
    issue      = '0;
    commit_rdy = 1'b1;
    foreach (model_regs[i]) model_regs[i] = '0;
    repeat (10) next_cycle();
    rst = 1'b0;

    // x1..x4 hold the edge operands
    for (int i = 1; i < 5; i++) issue_op(OP_ADD, 0, 0, edge_val(i), 1'b1, i, 1'b0);
    wait_drain();

    // independent back-to-back ops, fixed latency
    for (int i = 0; i < 8; i++) begin
      issue_op(rv_uop'(i[3:0]), 1 + i % 4, 4 - i % 4, '0, 1'b0, 24 + i, 1'b1);
    end
    wait_drain();

    // every uop on edge operands, register then immediate form
    k = 0;
    for (int u = 0; u < 10; u++) begin
      for (int a = 0; a < 5; a++) begin
        for (int b = 0; b < 5; b++) begin
          issue_op(rv_uop'(u[3:0]), a, b, '0, 1'b0, 5 + k % 8, 1'b0);
          issue_op(rv_uop'(u[3:0]), a, 0, edge_val(b), 1'b1, 5 + (k + 4) % 8, 1'b0);
          k++;
        end
      end
    end

    // dependent chain, each op reads the previous result
    issue_op(OP_ADD, 0, 0, 32'd123, 1'b1, 13, 1'b0);
    for (int i = 1; i < 16; i++) begin
      issue_op((i % 2 == 1) ? OP_SUB : OP_ADD, 12 + i, (i % 3 == 0) ? 12 + i : 3, '0,
               1'b0, 13 + i, 1'b0);
    end

    // x0 write commits, later reads still zero
    issue_op(OP_ADD, 1, 0, 32'h55, 1'b1, 0, 1'b0);
    issue_op(OP_ADD, 0, 0, '0, 1'b0, 9, 1'b0);
    issue_op(OP_OR, 0, 0, '0, 1'b1, 10, 1'b0);

    // random ops under commit back-pressure
    bp_on = 1'b1;
    for (int n = 0; n < num_random; n++) begin
      rnd   = lfsr_bits(4) % 10;
      r_uop = rv_uop'(rnd[3:0]);
      rnd   = lfsr_bits(3);
      r_sel = rnd[2:0];
      r_imm = (r_sel < 3'd4) ? edge_val(int'(r_sel)) : lfsr_bits(32);
      rnd   = lfsr_bits(16);  // rs1, rs2, rd, use_imm
      issue_op(r_uop, int'(rnd[4:0]), int'(rnd[9:5]), r_imm, rnd[15], int'(rnd[14:10]),
               1'b0);
    end
    wait_drain();
    bp_on = 1'b0;
    repeat (5) next_cycle();

    assert (commits == issued) else begin
      other_errs++;
      $display("%0d ops issued but %0d committed", issued, commits);
    end
    $display("errors: %0d value mismatches, %0d other, %0d assertion failures",
             value_errs, other_errs, dut.u_asserts.fail_cnt);
    if (value_errs + other_errs + dut.u_asserts.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/exec_asserts.sv
// protocol checks for the execute subsystem
// link stability, reset state, commit seq ordering
`timescale 1ns/1ps
`default_nettype none

module exec_asserts #(
  parameter int unsigned seq_num_bits = 5
) (
  input logic                clk,
  input logic                rst,
  input logic                issue_val,
  input logic                issue_rdy,
  input uarch_pkg::issue_t   issue,
  input logic                dx_val,
  input logic                dx_rdy,
  input uarch_pkg::d_x_t     dx,
  input logic                xw_val,
  input logic                xw_rdy,
  input uarch_pkg::x_w_t     xw,
  input logic                commit_val,
  input logic                commit_rdy,
  input uarch_pkg::commit_t  commit
);
  import uarch_pkg::*;

  localparam seq_t seq_mask = seq_t'((1 << seq_num_bits) - 1);

  int   fail_cnt = 0;  // failed assertion count
  seq_t exp_seq;       // seq the next commit must carry

  always_ff @(posedge clk) begin
    if (rst) begin
      exp_seq <= '0;
    end else if (commit_val && commit_rdy) begin
      exp_seq <= (exp_seq + 1'b1) & seq_mask;  // wraps with the counter
    end
  end

  // --------------------------------------------------
  // val and payload held until transfer
  // --------------------------------------------------

  issue_hold: assert property (@(posedge clk) disable iff (rst)
    issue_val && !issue_rdy |=> issue_val && $stable(issue))
    else begin fail_cnt++; $error("issue link changed before transfer"); end

  dx_hold: assert property (@(posedge clk) disable iff (rst)
    dx_val && !dx_rdy |=> dx_val && $stable(dx))
    else begin fail_cnt++; $error("dispatch to alu link changed before transfer"); end

  xw_hold: assert property (@(posedge clk) disable iff (rst)
    xw_val && !xw_rdy |=> xw_val && $stable(xw))
    else begin fail_cnt++; $error("alu to writeback link changed before transfer"); end

  commit_hold: assert property (@(posedge clk) disable iff (rst)
    commit_val && !commit_rdy |=> commit_val && $stable(commit))
    else begin fail_cnt++; $error("commit link changed before transfer"); end

  // --------------------------------------------------
  // reset and ordering
  // --------------------------------------------------

  ctrl_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({issue_rdy, dx_val, dx_rdy, xw_val, xw_rdy, commit_val}))
    else begin fail_cnt++; $error("control output is X after reset"); end

  reset_quiet: assert property (@(posedge clk)
    rst && $past(rst) |-> !commit_val)
    else begin fail_cnt++; $error("commit_val high during reset"); end

  commit_order: assert property (@(posedge clk) disable iff (rst)
    commit_val |-> commit.seq_num == exp_seq)
    else begin fail_cnt++; $error("commit seq_num out of order"); end

endmodule

bind exec_top exec_asserts #(.seq_num_bits(seq_num_bits)) u_asserts (
  .clk(clk), .rst(rst),
  .issue_val(issue_val), .issue_rdy(issue_rdy), .issue(issue),
  .dx_val(dx_val), .dx_rdy(dx_rdy), .dx(dx),
  .xw_val(xw_val), .xw_rdy(xw_rdy), .xw(xw),
  .commit_val(commit_val), .commit_rdy(commit_rdy), .commit(commit)
);

`default_nettype wire

// File: source/exec_top.sv
// execute subsystem top level
// dispatch -> alu -> writeback, plus the shared register file
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
  parameter int unsigned seq_num_bits = 5
) (
  input  logic               clk,
  input  logic               rst,
  // decoded ops in
  input  logic               issue_val,
  output logic               issue_rdy,
  input  uarch_pkg::issue_t  issue,
  // retired ops out
  output logic               commit_val,
  input  logic               commit_rdy,
  output uarch_pkg::commit_t commit
);
  import uarch_pkg::*;

  // ------------------------------------------------
  // stage links
  // ------------------------------------------------

  logic     dx_val;
  logic     dx_rdy;
  d_x_t     dx;
  logic     xw_val;
  logic     xw_rdy;
  x_w_t     xw;

  // regfile side nets
  reg_idx_t rs1;
  reg_idx_t rs2;
  data_t    rdata1;
  data_t    rdata2;
  logic     wen;
  reg_idx_t waddr;
  data_t    wdata;
  logic     clr_en;   // busy clear, wb -> dispatch
  reg_idx_t clr_idx;

  dispatch_stage #(.seq_num_bits(seq_num_bits)) u_dispatch (
    .clk, .rst,
    .issue_val, .issue_rdy, .issue,
    .rs1, .rs2, .rdata1, .rdata2,
    .clr_en, .clr_idx,
    .dx_val, .dx_rdy, .dx
  );

  alu_stage #(.seq_num_bits(seq_num_bits)) u_alu (
    .clk, .rst,
    .dx_val, .dx_rdy, .dx,
    .xw_val, .xw_rdy, .xw
  );

  writeback_stage #(.seq_num_bits(seq_num_bits)) u_wb (
    .clk, .rst,
    .xw_val, .xw_rdy, .xw,
    .wen, .waddr, .wdata,
    .clr_en, .clr_idx,
    .commit_val, .commit_rdy, .commit
  );

  reg_file u_rf (
    .clk, .rst,
    .rs1, .rs2, .rdata1, .rdata2,
    .wen, .waddr, .wdata
  );

endmodule

`default_nettype wire

// File: source/writeback_stage.sv
// writeback stage with a one-entry result register
// drives regfile write, busy clear and the commit port
`timescale 1ns/1ps
`default_nettype none

module writeback_stage #(
  parameter int unsigned seq_num_bits = 5
) (
  input  logic                clk,
  input  logic                rst,
  // alu -> writeback link
  input  logic                xw_val,
  output logic                xw_rdy,
  input  uarch_pkg::x_w_t     xw,
  // register file write port
  output logic                wen,
  output uarch_pkg::reg_idx_t waddr,
  output uarch_pkg::data_t    wdata,
  // busy clear back to dispatch
  output logic                clr_en,
  output uarch_pkg::reg_idx_t clr_idx,
  // commit link
  output logic                commit_val,
  input  logic                commit_rdy,
  output uarch_pkg::commit_t  commit
);
  import uarch_pkg::*;

  x_w_t ent;        // held result
  x_w_t ent_next;
  logic ent_val;
  logic xw_xfer;
  logic commit_xfer;

  // ------------------------------------------------
  // result register
  // ------------------------------------------------

  assign xw_xfer     = xw_val && xw_rdy;
  assign commit_xfer = commit_val && commit_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_val <= 1'b0;
    end else if (xw_xfer) begin
      ent_val <= 1'b1;
    end else if (commit_xfer) begin
      ent_val <= 1'b0;
    end
  end

  always_comb begin
    ent_next         = xw;
    ent_next.seq_num = seq_t'(xw.seq_num[seq_num_bits-1:0]);  // keep unused bits 0
  end

  always_ff @(posedge clk) begin
    if (xw_xfer) begin
      ent <= ent_next;
    end
  end

  assign xw_rdy     = commit_rdy || !ent_val;
  assign commit_val = ent_val;

  // ------------------------------------------------
  // retire side effects, only on the commit edge
  // ------------------------------------------------

  assign wen     = commit_xfer;
  assign waddr   = ent.waddr;
  assign wdata   = ent.wdata;
  assign clr_en  = commit_xfer;  // regfile and busy bit change on same edge
  assign clr_idx = ent.waddr;

  always_comb begin
    commit.pc      = ent.pc;
    commit.seq_num = ent.seq_num;
    commit.waddr   = ent.waddr;
    commit.wdata   = ent.wdata;
  end

endmodule

`default_nettype wire

// File: source/alu_stage.sv
// alu stage, one-entry execute register between dispatch and writeback
// full rv32i register/immediate alu set
`timescale 1ns/1ps
`default_nettype none

module alu_stage #(
  parameter int unsigned seq_num_bits = 5
) (
  input  logic              clk,
  input  logic              rst,
  // dispatch -> alu link
  input  logic              dx_val,
  output logic              dx_rdy,
  input  uarch_pkg::d_x_t   dx,
  // alu -> writeback link
  output logic              xw_val,
  input  logic              xw_rdy,
  output uarch_pkg::x_w_t   xw
);
  import uarch_pkg::*;

  d_x_t     ent;      // registered op, payload only
  d_x_t     ent_next;
  logic     ent_val;
  logic     dx_xfer;
  logic     xw_xfer;
  data_t    op1;
  data_t    op2;
  logic [4:0] shamt;
  data_t    result;

  // ------------------------------------------------
  // input register
  // ------------------------------------------------

  assign dx_xfer = dx_val && dx_rdy;
  assign xw_xfer = xw_val && xw_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_val <= 1'b0;
    end else if (dx_xfer) begin
      ent_val <= 1'b1;   // fill, also covers drain+fill in one cycle
    end else if (xw_xfer) begin
      ent_val <= 1'b0;   // drain
    end
  end

  always_comb begin
    ent_next         = dx;
    // only the low seq_num_bits are meaningful
    ent_next.seq_num = seq_t'(dx.seq_num[seq_num_bits-1:0]);
  end

  always_ff @(posedge clk) begin
    if (dx_xfer) begin
      ent <= ent_next;
    end
  end

  // ------------------------------------------------
  // arithmetic
  // ------------------------------------------------

  assign op1   = ent.op1;
  assign op2   = ent.op2;
  assign shamt = op2[4:0];  // rv32 shifts take low 5 bits

  always_comb begin
    case (ent.uop)
      OP_ADD:  result = op1 + op2;
      OP_SUB:  result = op1 - op2;
      OP_AND:  result = op1 & op2;
      OP_OR:   result = op1 | op2;
      OP_XOR:  result = op1 ^ op2;
      OP_SLL:  result = op1 << shamt;
      OP_SRL:  result = op1 >> shamt;
      OP_SRA:  result = data_t'($signed(op1) >>> shamt);  // sign fill
      OP_SLT:  result = data_t'($signed(op1) < $signed(op2));
      OP_SLTU: result = data_t'(op1 < op2);
      default: result = '0;  // unused encodings
    endcase
  end

  // ------------------------------------------------
  // outputs
  // ------------------------------------------------

  // free when empty or when the held op leaves this cycle
  assign dx_rdy = xw_rdy || !ent_val;
  assign xw_val = ent_val;

  always_comb begin
    xw.pc      = ent.pc;
    xw.seq_num = ent.seq_num;
    xw.waddr   = ent.waddr;
    xw.wdata   = result;
  end

endmodule

`default_nettype wire

// File: source/dispatch_stage.sv
// dispatch stage with one-entry input register and busy-bit scoreboard
// operand read with immediate select, sequence numbering
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage #(
  parameter int unsigned seq_num_bits = 5
) (
  input  logic                clk,
  input  logic                rst,
  // issue link
  input  logic                issue_val,
  output logic                issue_rdy,
  input  uarch_pkg::issue_t   issue,
  // register file read
  output uarch_pkg::reg_idx_t rs1,
  output uarch_pkg::reg_idx_t rs2,
  input  uarch_pkg::data_t    rdata1,
  input  uarch_pkg::data_t    rdata2,
  // busy clear from writeback
  input  logic                clr_en,
  input  uarch_pkg::reg_idx_t clr_idx,
  // dispatch -> alu link
  output logic                dx_val,
  input  logic                dx_rdy,
  output uarch_pkg::d_x_t     dx
);
  import uarch_pkg::*;

  issue_t                  ent;      // held op, no reset on payload
  logic                    ent_val;
  logic [num_regs-1:0]     busy;     // one bit per reg with a write in flight
  logic [seq_num_bits-1:0] seq_q;    // next seq number to hand out
  logic                    issue_xfer;
  logic                    dx_xfer;
  logic                    rs1_busy;
  logic                    rs2_busy;
  logic                    dst_busy;
  logic                    hazard;

  // ------------------------------------------------
  // hazard check
  // ------------------------------------------------

  assign rs1_busy = busy[ent.rs1];
  assign rs2_busy = busy[ent.rs2] && !ent.use_imm;  // rs2 unread in imm form
  // a second write to a reg still in flight would let its first
  // commit clear the bit early, so hold those too
  assign dst_busy = busy[ent.waddr];
  assign hazard   = rs1_busy || rs2_busy || dst_busy;

  // ------------------------------------------------
  // handshake
  // ------------------------------------------------

  assign dx_val     = ent_val && !hazard;
  assign dx_xfer    = dx_val && dx_rdy;
  assign issue_rdy  = !ent_val || dx_xfer;  // empty, or entry leaving now
  assign issue_xfer = issue_val && issue_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_val <= 1'b0;
    end else if (issue_xfer) begin
      ent_val <= 1'b1;
    end else if (dx_xfer) begin
      ent_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_xfer) begin
      ent <= issue;
    end
  end

  // ------------------------------------------------
  // scoreboard and sequence counter
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= '0;
      seq_q <= '0;
    end else begin
      if (clr_en) begin
        busy[clr_idx] <= 1'b0;
      end
      // later assignment wins, so a set beats a clear on the same bit
      if (dx_xfer && (ent.waddr != '0)) begin
        busy[ent.waddr] <= 1'b1;
      end
      if (dx_xfer) begin
        seq_q <= seq_q + 1'b1;  // wraps at 2**seq_num_bits
      end
    end
  end

  // ------------------------------------------------
  // operand read and outgoing payload
  // ------------------------------------------------

  assign rs1 = ent.rs1;
  assign rs2 = ent.rs2;

  always_comb begin
    dx.pc      = ent.pc;
    dx.seq_num = seq_t'(seq_q);  // upper bits zero
    dx.op1     = rdata1;
    dx.op2     = ent.use_imm ? ent.imm : rdata2;
    dx.waddr   = ent.waddr;
    dx.uop     = ent.uop;
  end

endmodule

`default_nettype wire

// File: source/reg_file.sv
// architectural register file, 32 x 32 bit
// two combinational read ports, one write port, x0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                clk,
  input  logic                rst,
  // read side, driven by dispatch
  input  uarch_pkg::reg_idx_t rs1,
  input  uarch_pkg::reg_idx_t rs2,
  output uarch_pkg::data_t    rdata1,
  output uarch_pkg::data_t    rdata2,
  // write side, driven by writeback
  input  logic                wen,
  input  uarch_pkg::reg_idx_t waddr,
  input  uarch_pkg::data_t    wdata
);
  import uarch_pkg::*;

  // x1..x31 only, no storage behind x0
  data_t regs [1:num_regs-1];

  // ------------------------------------------------
  // write port
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;  // architectural state starts at zero
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;  // writes to x0 dropped here
    end
  end

  // ------------------------------------------------
  // read ports
  // ------------------------------------------------

  // same-cycle write is not bypassed, the scoreboard keeps readers back
  // until the edge after the write
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/uarch_pkg.sv
// shared widths and typedefs for the execute subsystem
// alu op encoding, payload structs for each stage boundary
`default_nettype none

package uarch_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------

  localparam int unsigned xlen         = 32;  // rv32, fixed
  localparam int unsigned num_regs     = 32;  // architectural regs incl x0
  localparam int unsigned seq_max_bits = 8;   // widest seq_num a struct can carry

  typedef logic [xlen-1:0]         addr_t;     // program counter
  typedef logic [xlen-1:0]         data_t;     // register value
  typedef logic [4:0]              reg_idx_t;  // x0..x31
  typedef logic [seq_max_bits-1:0] seq_t;      // only low seq_num_bits used

  // ------------------------------------------------
  // alu ops, register and immediate forms share one code
  // ------------------------------------------------

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9
  } rv_uop;

  // ------------------------------------------------
  // stage payloads
  // ------------------------------------------------

  // decoded op from outside
  typedef struct packed {
    addr_t    pc;
    rv_uop    uop;
    reg_idx_t rs1;
    reg_idx_t rs2;
    data_t    imm;
    logic     use_imm;  // op2 = imm instead of rs2
    reg_idx_t waddr;
  } issue_t;

  // dispatch -> alu, operands already read
  typedef struct packed {
    addr_t    pc;
    seq_t     seq_num;
    data_t    op1;
    data_t    op2;
    reg_idx_t waddr;
    rv_uop    uop;
  } d_x_t;

  // alu -> writeback
  typedef struct packed {
    addr_t    pc;
    seq_t     seq_num;
    reg_idx_t waddr;
    data_t    wdata;
  } x_w_t;

  // retired op on the commit port
  typedef struct packed {
    addr_t    pc;
    seq_t     seq_num;
    reg_idx_t waddr;
    data_t    wdata;
  } commit_t;

endpackage

`default_nettype wire
